/* design/rv_core_pkg.sv */
package rv_core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // ALU functions and branch compares share one field
    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_BEQ,
        ALU_BNE,
        ALU_BLT,
        ALU_BGE,
        ALU_BLTU,
        ALU_BGEU,
        ALU_NONE
    } alu_op_e;

    typedef enum logic [1:0] {
        OP1_RS1,
        OP1_PC,
        OP1_ZERO
    } op1_sel_e;

    typedef enum logic [2:0] {
        OP2_RS2,
        OP2_IMM_I,
        OP2_IMM_S,
        OP2_IMM_J,
        OP2_IMM_U
    } op2_sel_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC_PLUS4,
        WB_NONE
    } wb_sel_e;

    // ----------------------------------------
    // Addresses

    localparam word_t START_ADDR  = 32'h0000_0000;
    localparam word_t PROGRAM_END = 32'd512;

    // addi x0, x0, 0
    localparam word_t BUBBLE = 32'h0000_0013;

    // ----------------------------------------
    // Major opcodes

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

endpackage

/* design/fetch_stage.sv */
`timescale 1ns/1ns

module fetch_stage (
    input  logic               clk_b,
    input  logic               reset,
    input  logic               redirect,
    input  rv_core_pkg::word_t redirect_pc,
    input  logic               stall,
    input  rv_core_pkg::word_t imem_inst,
    output rv_core_pkg::word_t imem_addr,
    output rv_core_pkg::word_t id_pc,
    output rv_core_pkg::word_t id_inst,
    output logic               exit
);

    rv_core_pkg::word_t pc;
    rv_core_pkg::word_t pc_next;

    assign imem_addr = pc;
    assign exit      = (pc == rv_core_pkg::PROGRAM_END);

    // Redirect beats stall, stall and halt both hold
    always_comb begin
        if (redirect) begin
            pc_next = redirect_pc;
        end else if (stall || exit) begin
            pc_next = pc;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk_b or posedge reset) begin
        if (reset) begin
            pc <= rv_core_pkg::START_ADDR;
        end else begin
            pc <= pc_next;
        end
    end

    // ----------------------------------------
    // IF/ID register

    always_ff @(posedge clk_b or posedge reset) begin
        if (reset) begin
            id_inst <= rv_core_pkg::BUBBLE;
        end else if (redirect) begin
            id_inst <= rv_core_pkg::BUBBLE;
        end else if (!stall) begin
            id_inst <= imem_inst;
        end
    end

    always_ff @(posedge clk_b) begin
        if (!stall) begin
            id_pc <= pc;
        end
    end

    // Redirect targets come from execute
    pc_aligned: assert property (@(posedge clk_b) disable iff (reset) pc[1:0] == 2'b00);

endmodule

/* design/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage (
    input  logic                   clk_b,
    input  logic                   reset,
    input  rv_core_pkg::word_t     id_pc,
    input  rv_core_pkg::word_t     id_inst,
    input  logic                   redirect,
    input  rv_core_pkg::word_t     rs1_rdata,
    input  rv_core_pkg::word_t     rs2_rdata,
    input  rv_core_pkg::reg_addr_t mem_rd,
    input  logic                   mem_rf_wen,
    input  rv_core_pkg::word_t     mem_wb_data,
    input  rv_core_pkg::reg_addr_t wb_rd,
    input  logic                   wb_rf_wen,
    input  rv_core_pkg::word_t     wb_data,
    output logic                   stall,
    output rv_core_pkg::reg_addr_t rs1_addr,
    output rv_core_pkg::reg_addr_t rs2_addr,
    output rv_core_pkg::word_t     ex_pc,
    output rv_core_pkg::word_t     ex_op1,
    output rv_core_pkg::word_t     ex_op2,
    output rv_core_pkg::word_t     ex_rs2_data,
    output rv_core_pkg::word_t     ex_imm_b,
    output rv_core_pkg::reg_addr_t ex_rd,
    output logic                   ex_rf_wen,
    output logic                   ex_mem_wen,
    output rv_core_pkg::wb_sel_e   ex_wb_sel,
    output rv_core_pkg::alu_op_e   ex_alu_op
);

    rv_core_pkg::word_t   inst;
    rv_core_pkg::word_t   imm_i;
    rv_core_pkg::word_t   imm_s;
    rv_core_pkg::word_t   imm_b;
    rv_core_pkg::word_t   imm_j;
    rv_core_pkg::word_t   imm_u;
    rv_core_pkg::word_t   rs1_data;
    rv_core_pkg::word_t   rs2_data;
    rv_core_pkg::word_t   op1;
    rv_core_pkg::word_t   op2;
    rv_core_pkg::alu_op_e arith_op;
    rv_core_pkg::alu_op_e branch_op;
    rv_core_pkg::alu_op_e alu_op;
    rv_core_pkg::op1_sel_e op1_sel;
    rv_core_pkg::op2_sel_e op2_sel;
    rv_core_pkg::wb_sel_e wb_sel;
    logic                 mem_wen;

    // Load-use and ALU-use hazard against the instruction in execute
    assign stall = ex_rf_wen && (ex_rd != '0) &&
                   ((ex_rd == id_inst[19:15]) || (ex_rd == id_inst[24:20]));

    assign inst     = (redirect || stall) ? rv_core_pkg::BUBBLE : id_inst;
    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};

    // Memory stage is younger, so it wins over writeback
    function automatic rv_core_pkg::word_t bypass(input rv_core_pkg::reg_addr_t addr,
                                                  input rv_core_pkg::word_t rf_data);
        if (addr == '0) begin
            return '0;
        end else if (mem_rf_wen && (mem_rd == addr)) begin
            return mem_wb_data;
        end else if (wb_rf_wen && (wb_rd == addr)) begin
            return wb_data;
        end
        return rf_data;
    endfunction

    always_comb begin
        rs1_data = bypass(rs1_addr, rs1_rdata);
        rs2_data = bypass(rs2_addr, rs2_rdata);
    end

    // ----------------------------------------
    // Instruction decode

    always_comb begin
        case (inst[14:12])
            3'b000:  arith_op = (inst[6:0] == rv_core_pkg::OPC_OP && inst[30]) ?
                                rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
            3'b001:  arith_op = rv_core_pkg::ALU_SLL;
            3'b010:  arith_op = rv_core_pkg::ALU_SLT;
            3'b011:  arith_op = rv_core_pkg::ALU_SLTU;
            3'b100:  arith_op = rv_core_pkg::ALU_XOR;
            3'b101:  arith_op = inst[30] ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
            3'b110:  arith_op = rv_core_pkg::ALU_OR;
            default: arith_op = rv_core_pkg::ALU_AND;
        endcase
        case (inst[14:12])
            3'b000:  branch_op = rv_core_pkg::ALU_BEQ;
            3'b001:  branch_op = rv_core_pkg::ALU_BNE;
            3'b100:  branch_op = rv_core_pkg::ALU_BLT;
            3'b101:  branch_op = rv_core_pkg::ALU_BGE;
            3'b110:  branch_op = rv_core_pkg::ALU_BLTU;
            3'b111:  branch_op = rv_core_pkg::ALU_BGEU;
            default: branch_op = rv_core_pkg::ALU_NONE;
        endcase
    end

    // Unknown opcodes keep the no-op defaults
    always_comb begin
        alu_op  = rv_core_pkg::ALU_NONE;
        op1_sel = rv_core_pkg::OP1_RS1;
        op2_sel = rv_core_pkg::OP2_RS2;
        wb_sel  = rv_core_pkg::WB_NONE;
        mem_wen = 1'b0;
        case (inst[6:0])
            rv_core_pkg::OPC_LUI, rv_core_pkg::OPC_AUIPC: begin
                alu_op  = rv_core_pkg::ALU_ADD;
                op1_sel = inst[5] ? rv_core_pkg::OP1_ZERO : rv_core_pkg::OP1_PC;
                op2_sel = rv_core_pkg::OP2_IMM_U;
                wb_sel  = rv_core_pkg::WB_ALU;
            end
            rv_core_pkg::OPC_JAL: begin
                alu_op  = rv_core_pkg::ALU_ADD;
                op1_sel = rv_core_pkg::OP1_PC;
                op2_sel = rv_core_pkg::OP2_IMM_J;
                wb_sel  = rv_core_pkg::WB_PC_PLUS4;
            end
            rv_core_pkg::OPC_JALR: begin
                alu_op  = rv_core_pkg::ALU_ADD;
                op2_sel = rv_core_pkg::OP2_IMM_I;
                wb_sel  = rv_core_pkg::WB_PC_PLUS4;
            end
            rv_core_pkg::OPC_BRANCH: alu_op = branch_op;
            rv_core_pkg::OPC_LOAD: begin
                alu_op  = rv_core_pkg::ALU_ADD;
                op2_sel = rv_core_pkg::OP2_IMM_I;
                wb_sel  = rv_core_pkg::WB_MEM;
            end
            rv_core_pkg::OPC_STORE: begin
                alu_op  = rv_core_pkg::ALU_ADD;
                op2_sel = rv_core_pkg::OP2_IMM_S;
                mem_wen = 1'b1;
            end
            rv_core_pkg::OPC_OP_IMM: begin
                alu_op  = arith_op;
                op2_sel = rv_core_pkg::OP2_IMM_I;
                wb_sel  = rv_core_pkg::WB_ALU;
            end
            rv_core_pkg::OPC_OP: begin
                alu_op  = arith_op;
                wb_sel  = rv_core_pkg::WB_ALU;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (op1_sel)
            rv_core_pkg::OP1_PC:   op1 = id_pc;
            rv_core_pkg::OP1_ZERO: op1 = '0;
            default:               op1 = rs1_data;
        endcase
        case (op2_sel)
            rv_core_pkg::OP2_IMM_I: op2 = imm_i;
            rv_core_pkg::OP2_IMM_S: op2 = imm_s;
            rv_core_pkg::OP2_IMM_J: op2 = imm_j;
            rv_core_pkg::OP2_IMM_U: op2 = imm_u;
            default:                op2 = rs2_data;
        endcase
    end

    // ----------------------------------------
    // ID/EX register

    always_ff @(posedge clk_b or posedge reset) begin
        if (reset) begin
            ex_rf_wen  <= 1'b0;
            ex_mem_wen <= 1'b0;
            ex_wb_sel  <= rv_core_pkg::WB_NONE;
            ex_alu_op  <= rv_core_pkg::ALU_NONE;
        end else begin
            ex_rf_wen  <= (wb_sel != rv_core_pkg::WB_NONE);
            ex_mem_wen <= mem_wen;
            ex_wb_sel  <= wb_sel;
            ex_alu_op  <= alu_op;
        end
    end

    always_ff @(posedge clk_b) begin
        ex_pc       <= id_pc;
        ex_op1      <= op1;
        ex_op2      <= op2;
        ex_rs2_data <= rs2_data;
        ex_imm_b    <= imm_b;
        ex_rd       <= inst[11:7];
    end

endmodule

/* design/register_file.sv */
`timescale 1ns/1ns

module register_file (
    input  logic                   clk_b,
    input  rv_core_pkg::reg_addr_t rs1_addr,
    input  rv_core_pkg::reg_addr_t rs2_addr,
    input  rv_core_pkg::reg_addr_t wb_rd,
    input  logic                   wb_rf_wen,
    input  rv_core_pkg::word_t     wb_data,
    output rv_core_pkg::word_t     rs1_rdata,
    output rv_core_pkg::word_t     rs2_rdata
);

    // x0 has no storage
    rv_core_pkg::word_t regs [1:31];

    always_ff @(posedge clk_b) begin
        if (wb_rf_wen) begin
            regs[wb_rd] <= wb_data;
        end
    end

    assign rs1_rdata = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_rdata = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    // Memory stage masks x0 before MEM/WB
    no_x0_write: assert property (@(posedge clk_b) wb_rf_wen |-> wb_rd != '0);

endmodule

/* design/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage (
    input  logic                   clk_b,
    input  logic                   reset,
    input  rv_core_pkg::word_t     ex_pc,
    input  rv_core_pkg::word_t     ex_op1,
    input  rv_core_pkg::word_t     ex_op2,
    input  rv_core_pkg::word_t     ex_rs2_data,
    input  rv_core_pkg::word_t     ex_imm_b,
    input  rv_core_pkg::reg_addr_t ex_rd,
    input  logic                   ex_rf_wen,
    input  logic                   ex_mem_wen,
    input  rv_core_pkg::wb_sel_e   ex_wb_sel,
    input  rv_core_pkg::alu_op_e   ex_alu_op,
    output logic                   redirect,
    output rv_core_pkg::word_t     redirect_pc,
    output rv_core_pkg::word_t     mem_pc,
    output rv_core_pkg::word_t     mem_alu_out,
    output rv_core_pkg::word_t     mem_rs2_data,
    output rv_core_pkg::reg_addr_t mem_rd,
    output logic                   mem_rf_wen,
    output logic                   mem_mem_wen,
    output rv_core_pkg::wb_sel_e   mem_wb_sel
);

    rv_core_pkg::word_t alu_out;
    logic               br_taken;
    logic               jump;

    always_comb begin
        alu_out  = '0;
        br_taken = 1'b0;
        case (ex_alu_op)
            rv_core_pkg::ALU_ADD:  alu_out = ex_op1 + ex_op2;
            rv_core_pkg::ALU_SUB:  alu_out = ex_op1 - ex_op2;
            rv_core_pkg::ALU_AND:  alu_out = ex_op1 & ex_op2;
            rv_core_pkg::ALU_OR:   alu_out = ex_op1 | ex_op2;
            rv_core_pkg::ALU_XOR:  alu_out = ex_op1 ^ ex_op2;
            rv_core_pkg::ALU_SLL:  alu_out = ex_op1 << ex_op2[4:0];
            rv_core_pkg::ALU_SRL:  alu_out = ex_op1 >> ex_op2[4:0];
            rv_core_pkg::ALU_SRA:  alu_out = $signed(ex_op1) >>> ex_op2[4:0];
            rv_core_pkg::ALU_SLT:  alu_out = {31'b0, $signed(ex_op1) < $signed(ex_op2)};
            rv_core_pkg::ALU_SLTU: alu_out = {31'b0, ex_op1 < ex_op2};
            rv_core_pkg::ALU_BEQ:  br_taken = (ex_op1 == ex_op2);
            rv_core_pkg::ALU_BNE:  br_taken = (ex_op1 != ex_op2);
            rv_core_pkg::ALU_BLT:  br_taken = ($signed(ex_op1) < $signed(ex_op2));
            rv_core_pkg::ALU_BGE:  br_taken = ($signed(ex_op1) >= $signed(ex_op2));
            rv_core_pkg::ALU_BLTU: br_taken = (ex_op1 < ex_op2);
            rv_core_pkg::ALU_BGEU: br_taken = (ex_op1 >= ex_op2);
            default: ;
        endcase
    end

    // Only JAL and JALR link PC plus 4
    assign jump        = (ex_wb_sel == rv_core_pkg::WB_PC_PLUS4);
    assign redirect    = jump || br_taken;
    assign redirect_pc = jump ? {alu_out[31:1], 1'b0} : ex_pc + ex_imm_b;

    // ----------------------------------------
    // EX/MEM register

    always_ff @(posedge clk_b or posedge reset) begin
        if (reset) begin
            mem_rf_wen  <= 1'b0;
            mem_mem_wen <= 1'b0;
            mem_wb_sel  <= rv_core_pkg::WB_NONE;
        end else begin
            mem_rf_wen  <= ex_rf_wen;
            mem_mem_wen <= ex_mem_wen;
            mem_wb_sel  <= ex_wb_sel;
        end
    end

    always_ff @(posedge clk_b) begin
        mem_pc       <= ex_pc;
        mem_alu_out  <= alu_out;
        mem_rs2_data <= ex_rs2_data;
        mem_rd       <= ex_rd;
    end

    // Targets depend on decode immediates and the fetched PC
    redirect_aligned: assert property (@(posedge clk_b) disable iff (reset)
        redirect |-> redirect_pc[1:0] == 2'b00);

endmodule

/* design/memory_stage.sv */
`timescale 1ns/1ns

module memory_stage (
    input  logic                   clk_b,
    input  logic                   reset,
    input  rv_core_pkg::word_t     mem_pc,
    input  rv_core_pkg::word_t     mem_alu_out,
    input  rv_core_pkg::word_t     mem_rs2_data,
    input  rv_core_pkg::reg_addr_t mem_rd,
    input  logic                   mem_rf_wen,
    input  logic                   mem_mem_wen,
    input  rv_core_pkg::wb_sel_e   mem_wb_sel,
    input  rv_core_pkg::word_t     dmem_rdata,
    output rv_core_pkg::word_t     dmem_addr,
    output rv_core_pkg::word_t     dmem_wdata,
    output logic                   dmem_wen,
    output rv_core_pkg::word_t     mem_wb_data,
    output rv_core_pkg::reg_addr_t wb_rd,
    output logic                   wb_rf_wen,
    output rv_core_pkg::word_t     wb_data
);

    assign dmem_addr  = mem_alu_out;
    assign dmem_wdata = mem_rs2_data;
    assign dmem_wen   = mem_mem_wen;

    // Also feeds the decode bypass
    always_comb begin
        case (mem_wb_sel)
            rv_core_pkg::WB_MEM:      mem_wb_data = dmem_rdata;
            rv_core_pkg::WB_PC_PLUS4: mem_wb_data = mem_pc + 32'd4;
            default:                  mem_wb_data = mem_alu_out;
        endcase
    end

    // ----------------------------------------
    // MEM/WB register

    always_ff @(posedge clk_b or posedge reset) begin
        if (reset) begin
            wb_rf_wen <= 1'b0;
        end else begin
            wb_rf_wen <= mem_rf_wen && (mem_rd != '0);
        end
    end

    always_ff @(posedge clk_b) begin
        wb_rd   <= mem_rd;
        wb_data <= mem_wb_data;
    end

endmodule

/* design/rv_core.sv */
`timescale 1ns/1ns

module rv_core (
    input  logic               clk_b,
    input  logic               reset,
    input  rv_core_pkg::word_t imem_inst,
    input  rv_core_pkg::word_t dmem_rdata,
    output rv_core_pkg::word_t imem_addr,
    output rv_core_pkg::word_t dmem_addr,
    output rv_core_pkg::word_t dmem_wdata,
    output logic               dmem_wen,
    output logic               exit
);

    // Hazard control
    logic                   redirect;
    rv_core_pkg::word_t     redirect_pc;
    logic                   stall;

    // IF/ID
    rv_core_pkg::word_t     id_pc;
    rv_core_pkg::word_t     id_inst;

    // Register file reads
    rv_core_pkg::reg_addr_t rs1_addr;
    rv_core_pkg::reg_addr_t rs2_addr;
    rv_core_pkg::word_t     rs1_rdata;
    rv_core_pkg::word_t     rs2_rdata;

    // ID/EX
    rv_core_pkg::word_t     ex_pc;
    rv_core_pkg::word_t     ex_op1;
    rv_core_pkg::word_t     ex_op2;
    rv_core_pkg::word_t     ex_rs2_data;
    rv_core_pkg::word_t     ex_imm_b;
    rv_core_pkg::reg_addr_t ex_rd;
    logic                   ex_rf_wen;
    logic                   ex_mem_wen;
    rv_core_pkg::wb_sel_e   ex_wb_sel;
    rv_core_pkg::alu_op_e   ex_alu_op;

    // EX/MEM
    rv_core_pkg::word_t     mem_pc;
    rv_core_pkg::word_t     mem_alu_out;
    rv_core_pkg::word_t     mem_rs2_data;
    rv_core_pkg::reg_addr_t mem_rd;
    logic                   mem_rf_wen;
    logic                   mem_mem_wen;
    rv_core_pkg::wb_sel_e   mem_wb_sel;
    rv_core_pkg::word_t     mem_wb_data;

    // MEM/WB
    rv_core_pkg::reg_addr_t wb_rd;
    logic                   wb_rf_wen;
    rv_core_pkg::word_t     wb_data;

    // Port names match the nets above
    fetch_stage   fetch_stage_i   (.*);
    decode_stage  decode_stage_i  (.*);
    register_file register_file_i (.*);
    execute_stage execute_stage_i (.*);
    memory_stage  memory_stage_i  (.*);

endmodule

/* dv/rv_iss_model.svh */
`ifndef RV_ISS_MODEL_SVH
`define RV_ISS_MODEL_SVH

rv_core_pkg::word_t lfsr_state = 32'd53;

// Galois form stepped once per bit
function automatic logic lfsr_bit();
    logic lsb;
    lsb = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) begin
        lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return lsb;
endfunction

function automatic rv_core_pkg::word_t rand_bits(input int n);
    rv_core_pkg::word_t r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r = {r[30:0], lfsr_bit()};
    end
    return r;
endfunction

// Half the picks stay in x0..x7 to crowd the hazards
function automatic rv_core_pkg::reg_addr_t pick_reg();
    if (lfsr_bit()) begin
        return rv_core_pkg::reg_addr_t'(rand_bits(3));
    end
    return rv_core_pkg::reg_addr_t'(rand_bits(5));
endfunction

// ----------------------------------------
// Encoders

function automatic rv_core_pkg::word_t enc_i(input rv_core_pkg::word_t imm,
        input rv_core_pkg::reg_addr_t rs1, input logic [2:0] f3,
        input rv_core_pkg::reg_addr_t rd, input logic [6:0] opc);
    return {imm[11:0], rs1, f3, rd, opc};
endfunction

function automatic rv_core_pkg::word_t enc_r(input logic [6:0] f7,
        input rv_core_pkg::reg_addr_t rs2, input rv_core_pkg::reg_addr_t rs1,
        input logic [2:0] f3, input rv_core_pkg::reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, rv_core_pkg::OPC_OP};
endfunction

function automatic rv_core_pkg::word_t enc_s(input rv_core_pkg::word_t imm,
        input rv_core_pkg::reg_addr_t rs2, input rv_core_pkg::reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_core_pkg::OPC_STORE};
endfunction

function automatic rv_core_pkg::word_t enc_b(input rv_core_pkg::word_t off,
        input rv_core_pkg::reg_addr_t rs2, input rv_core_pkg::reg_addr_t rs1,
        input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_core_pkg::OPC_BRANCH};
endfunction

function automatic rv_core_pkg::word_t enc_u(input rv_core_pkg::word_t imm20,
        input rv_core_pkg::reg_addr_t rd, input logic [6:0] opc);
    return {imm20[19:0], rd, opc};
endfunction

function automatic rv_core_pkg::word_t enc_j(input rv_core_pkg::word_t off,
        input rv_core_pkg::reg_addr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv_core_pkg::OPC_JAL};
endfunction

// ----------------------------------------
// Sequential reference that runs one instruction per step

task automatic run_model();
    rv_core_pkg::word_t x [0:31];
    rv_core_pkg::word_t dm [0:255];
    rv_core_pkg::word_t pc;
    rv_core_pkg::word_t inst;
    rv_core_pkg::word_t a;
    rv_core_pkg::word_t b;
    rv_core_pkg::word_t res;
    rv_core_pkg::word_t next_pc;
    logic               take;
    logic               wr;
    int                 steps;
    for (int i = 0; i < 32; i++) begin
        x[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
        dm[i] = '0;
    end
    pc = rv_core_pkg::START_ADDR;
    steps = 0;
    while (pc != rv_core_pkg::PROGRAM_END) begin
        if (steps > 1000) begin
            $display("The reference model never reached the program end");
            $display("=== FAIL ===");
            $fatal(1, "model runaway");
        end
        steps++;
        inst = imem[pc[8:2]];
        a = x[inst[19:15]];
        b = x[inst[24:20]];
        next_pc = pc + 32'd4;
        res = '0;
        wr = 1'b1;
        case (inst[6:0])
            rv_core_pkg::OPC_LUI:   res = {inst[31:12], 12'b0};
            rv_core_pkg::OPC_AUIPC: res = pc + {inst[31:12], 12'b0};
            rv_core_pkg::OPC_JAL: begin
                res = pc + 32'd4;
                next_pc = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            rv_core_pkg::OPC_JALR: begin
                res = pc + 32'd4;
                next_pc = (a + {{20{inst[31]}}, inst[31:20]}) & ~32'd1;
            end
            rv_core_pkg::OPC_BRANCH: begin
                wr = 1'b0;
                case (inst[14:12])
                    3'b000:  take = (a == b);
                    3'b001:  take = (a != b);
                    3'b100:  take = ($signed(a) < $signed(b));
                    3'b101:  take = ($signed(a) >= $signed(b));
                    3'b110:  take = (a < b);
                    default: take = (a >= b);
                endcase
                if (take) begin
                    next_pc = pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                end
            end
            rv_core_pkg::OPC_LOAD: begin
                res = a + {{20{inst[31]}}, inst[31:20]};
                res = dm[res[9:2]];
            end
            rv_core_pkg::OPC_STORE: begin
                wr = 1'b0;
                res = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
                dm[res[9:2]] = b;
                exp_addr.push_back(res);
                exp_data.push_back(b);
            end
            default: begin
                // OP_IMM swaps rs2 for the I immediate
                if (inst[6:0] == rv_core_pkg::OPC_OP_IMM) begin
                    b = {{20{inst[31]}}, inst[31:20]};
                end
                // SUB only exists in OP
                case (inst[14:12])
                    3'b000:  res = (inst[5] && inst[30]) ? a - b : a + b;
                    3'b001:  res = a << b[4:0];
                    3'b010:  res = {31'b0, $signed(a) < $signed(b)};
                    3'b011:  res = {31'b0, a < b};
                    3'b100:  res = a ^ b;
                    3'b101: begin
                        if (inst[30]) begin
                            res = $signed(a) >>> b[4:0];
                        end else begin
                            res = a >> b[4:0];
                        end
                    end
                    3'b110:  res = a | b;
                    default: res = a & b;
                endcase
            end
        endcase
        if (wr && inst[11:7] != 5'd0) begin
            x[inst[11:7]] = res;
        end
        pc = next_pc;
    end
endtask

`endif

/* dv/rv_core_tb.sv */
`timescale 1ns/1ns

module rv_core_tb;

    logic               clk_b;
    logic               reset;
    rv_core_pkg::word_t imem_inst;
    rv_core_pkg::word_t dmem_rdata;
    rv_core_pkg::word_t imem_addr;
    rv_core_pkg::word_t dmem_addr;
    rv_core_pkg::word_t dmem_wdata;
    logic               dmem_wen;
    logic               exit;

    rv_core_pkg::word_t imem [0:127];
    rv_core_pkg::word_t dmem [0:255];
    rv_core_pkg::word_t exp_addr [$];
    rv_core_pkg::word_t exp_data [$];
    int                 store_count = 0;
    int                 cycles;

    `include "rv_iss_model.svh"

    rv_core rv_core_i (
        .clk_b      (clk_b),
        .reset      (reset),
        .imem_inst  (imem_inst),
        .dmem_rdata (dmem_rdata),
        .imem_addr  (imem_addr),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_wen   (dmem_wen),
        .exit       (exit)
    );

    initial clk_b = 1'b0;
    always #50 clk_b = ~clk_b;

    // Both memories answer in the same cycle
    assign imem_inst  = (imem_addr < 32'd512) ? imem[imem_addr[8:2]] : rv_core_pkg::BUBBLE;
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    // ----------------------------------------
    // Checks

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "run aborted");
    endtask

    task automatic compare_word(input string what, input rv_core_pkg::word_t got,
                                input rv_core_pkg::word_t expected);
        if (got !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            $display("=== FAIL ===");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic compare_bit(input string what, input logic got, input logic expected);
        if (got !== expected) begin
            $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, expected);
            $display("=== FAIL ===");
            $fatal(1, "bit mismatch");
        end
    endtask

    task automatic compare_count(input int got, input int expected);
        if (got != expected) begin
            $display("Error at %0t ns: %0d stores seen, expected %0d", $time, got, expected);
            $display("=== FAIL ===");
            $fatal(1, "count mismatch");
        end
    endtask

    // Store port is stable at the falling edge
    always @(negedge clk_b) begin
        if (!reset && dmem_wen === 1'b1) begin
            if (store_count >= exp_addr.size()) begin
                abort_run("The core made a store that the reference model never makes");
            end else begin
                compare_word("store address", dmem_addr, exp_addr[store_count]);
                compare_word("store data", dmem_wdata, exp_data[store_count]);
                dmem[dmem_addr[9:2]] = dmem_wdata;
                store_count = store_count + 1;
            end
        end
    end

    // ----------------------------------------
    // Program generator

    task automatic build_program();
        int                     k;
        logic [2:0]             f3;
        rv_core_pkg::reg_addr_t rd;
        rv_core_pkg::word_t     imm;
        for (int i = 0; i < 95; i++) begin
            // Forward targets stop at the register dump
            k = 1 + int'(rand_bits(7)) % (95 - i);
            f3 = 3'(rand_bits(3));
            rd = pick_reg();
            imm = rand_bits(12);
            case (rand_bits(4))
                0: imem[i] = enc_u(rand_bits(20), rd, rv_core_pkg::OPC_LUI);
                1: imem[i] = enc_u(rand_bits(20), rd, rv_core_pkg::OPC_AUIPC);
                2: imem[i] = enc_j(rv_core_pkg::word_t'(k * 4), rd);
                3: imem[i] = enc_i(rv_core_pkg::word_t'((i + k) * 4), 5'd0, 3'b000, rd,
                                   rv_core_pkg::OPC_JALR);
                4: begin
                    if (f3[2:1] == 2'b01) begin
                        f3 = {2'b00, f3[0]};
                    end
                    imem[i] = enc_b(rv_core_pkg::word_t'(k * 4), pick_reg(), pick_reg(), f3);
                end
                5, 6: imem[i] = enc_i(rand_bits(4) << 2, 5'd0, 3'b010, rd,
                                      rv_core_pkg::OPC_LOAD);
                7, 8: imem[i] = enc_s(rand_bits(4) << 2, pick_reg(), 5'd0);
                9, 10, 11: begin
                    if (f3 == 3'b001 || f3 == 3'b101) begin
                        imm[11] = 1'b0;
                        imm[9:5] = 5'b0;
                        imm[10] = imm[10] && (f3 == 3'b101);
                    end
                    imem[i] = enc_i(imm, pick_reg(), f3, rd, rv_core_pkg::OPC_OP_IMM);
                end
                default: imem[i] = enc_r({1'b0, imm[0] && (f3 == 3'b000 || f3 == 3'b101), 5'b0},
                                         pick_reg(), pick_reg(), f3, rd);
            endcase
        end
        for (int r = 1; r < 32; r++) begin
            imem[94 + r] = enc_s(rv_core_pkg::word_t'(256 + 4 * (r - 1)),
                                 rv_core_pkg::reg_addr_t'(r), 5'd0);
        end
        imem[126] = enc_i(32'd1, 5'd0, 3'b000, 5'd0, rv_core_pkg::OPC_OP_IMM);
        imem[127] = enc_i(32'd2, 5'd0, 3'b000, 5'd0, rv_core_pkg::OPC_OP_IMM);
    endtask

    // ----------------------------------------
    // Main sequence

    initial begin
        reset = 1'b1;
        for (int i = 0; i < 256; i++) begin
            dmem[i] = '0;
        end
        build_program();
        run_model();

        repeat (8) begin
            @(posedge clk_b);
            #1;
            compare_bit("dmem_wen in reset", dmem_wen, 1'b0);
            compare_bit("exit in reset", exit, 1'b0);
        end
        reset = 1'b0;
        compare_word("first imem_addr", imem_addr, rv_core_pkg::START_ADDR);

        // First edge out of reset only moves bubbles
        @(posedge clk_b);
        #1;
        compare_bit("dmem_wen after reset", dmem_wen, 1'b0);
        compare_bit("exit after reset", exit, 1'b0);

        cycles = 0;
        while (exit !== 1'b1) begin
            @(posedge clk_b);
            #1;
            cycles++;
            if (cycles > 2000) begin
                abort_run("Timed out waiting for exit to rise");
            end
        end

        // Pipeline drains while the PC holds
        repeat (4) begin
            @(posedge clk_b);
            #1;
            compare_bit("exit", exit, 1'b1);
        end
        compare_count(store_count, exp_addr.size());

        repeat (8) begin
            @(posedge clk_b);
            #1;
            compare_bit("exit", exit, 1'b1);
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

/* rv_core.f */
+incdir+dv
design/rv_core_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/register_file.sv
design/execute_stage.sv
design/memory_stage.sv
design/rv_core.sv
dv/rv_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f rv_core.f \
    --top-module rv_core_tb \
    -o rv_core_sim

./obj_dir/rv_core_sim
